// File: source/icache_pkg.sv
/*
 * Shared widths and constants of the fetch memory subsystem,
 * and the cache line union with its field layout.
 */

package icache_pkg;

	localparam int ADDR_BITS  = 15;	// word address.
	localparam int DATA_BITS  = 16;
	localparam int INDEX_BITS = 8;	// 256 cache lines.
	localparam int LINE_BITS  = 32;
	localparam int MEM_WORDS  = 32768;

	// only the invalid flag set.
	localparam logic [LINE_BITS-1:0] INVALID_LINE = 32'h0001_0000;

	// line layout, tag on top, instruction at the bottom.
	typedef struct packed {
		logic [ADDR_BITS-1:0] tag;
		logic invalid;	// zero means valid.
		logic [DATA_BITS-1:0] instr;
	} cache_fields_t;

	typedef union packed {
		logic [LINE_BITS-1:0] raw;
		cache_fields_t fields;
	} cache_line_u;

endpackage

// File: source/bram.sv
/*
 * Simple dual-port line RAM for the instruction cache.
 * Synchronous read and write, every line invalid at start-up.
 */

`timescale 1ns/1ps

module bram (
	input  logic CLK,
	input  logic [icache_pkg::INDEX_BITS-1:0] rd_address,
	output logic [icache_pkg::LINE_BITS-1:0] data_out,
	input  logic [icache_pkg::INDEX_BITS-1:0] wr_address,
	input  logic [icache_pkg::LINE_BITS-1:0] data_in,
	input  logic wr
);

	logic [icache_pkg::LINE_BITS-1:0] ram [0:(1 << icache_pkg::INDEX_BITS)-1];

	initial begin
		for (int i = 0; i < (1 << icache_pkg::INDEX_BITS); i++) begin
			ram[i] = icache_pkg::INVALID_LINE;
		end
	end

	always_ff @(posedge CLK) begin
		if (wr) begin
			ram[wr_address] <= data_in;
		end
		data_out <= ram[rd_address];	// old data on a same-index write.
	end

endmodule

// File: source/cpu_instruction_cache.sv
/*
 * Direct-mapped instruction cache, 256 lines of tag, flag and word.
 * Tag compare and miss flag, fill writes from the arbiter,
 * and the prefetch sequencer that walks the rest of the page.
 */

`timescale 1ns/1ps

module cpu_instruction_cache (
	input  logic CLK,
	input  logic RSTb,

	input  logic [icache_pkg::ADDR_BITS-1:0] cache_request_address,
	output logic [icache_pkg::DATA_BITS-1:0] instruction,
	output logic cache_miss,

	output logic [icache_pkg::ADDR_BITS-1:0] memory_address,
	output logic memory_rd_req,
	input  logic memory_success,
	input  logic [icache_pkg::ADDR_BITS-1:0] memory_requested_address,
	input  logic [icache_pkg::DATA_BITS-1:0] memory_data,
	input  logic will_queue
);

	logic [icache_pkg::LINE_BITS-1:0] data_out;
	icache_pkg::cache_line_u rd_line;
	icache_pkg::cache_line_u fill_line;

	logic [icache_pkg::ADDR_BITS-1:0] address_x;	// request, one cycle old.
	logic [icache_pkg::ADDR_BITS-1:0] address_xx;	// request, two cycles old.
	logic [icache_pkg::INDEX_BITS:0] fill_index;	// top bit marks end of page.
	logic new_miss;

	// ****************************************
	// line storage
	// ****************************************

	always_comb begin
		fill_line.fields.tag = memory_requested_address;
		fill_line.fields.invalid = 1'b0;
		fill_line.fields.instr = memory_data;
	end

	bram line_ram (
		.CLK(CLK),
		.rd_address(cache_request_address[icache_pkg::INDEX_BITS-1:0]),
		.data_out(data_out),
		.wr_address(memory_requested_address[icache_pkg::INDEX_BITS-1:0]),
		.data_in(fill_line.raw),
		.wr(memory_success)
	);

	assign rd_line.raw = data_out;

	// line and address_x belong to the same request.
	assign cache_miss = (rd_line.fields.tag != address_x) || rd_line.fields.invalid;
	assign instruction = rd_line.fields.instr;

	// ****************************************
	// fill sequencer
	// ****************************************

	assign new_miss = (address_x != address_xx) && cache_miss;

	// page from the older request, index from the sequencer.
	assign memory_address = {address_xx[icache_pkg::ADDR_BITS-1:icache_pkg::INDEX_BITS],
		fill_index[icache_pkg::INDEX_BITS-1:0]};

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			address_x <= '0;
			address_xx <= '0;
			fill_index <= '0;
			memory_rd_req <= 1'b1;	// start by filling page 0.
		end else begin
			address_x <= cache_request_address;
			address_xx <= address_x;

			if (new_miss) begin
				fill_index <= {1'b0, address_x[icache_pkg::INDEX_BITS-1:0]};
				memory_rd_req <= 1'b1;
			end else if (!fill_index[icache_pkg::INDEX_BITS] && will_queue) begin
				fill_index <= fill_index + 1'b1;	// keep the memory pipeline busy.
				memory_rd_req <= 1'b1;
			end else if (fill_index[icache_pkg::INDEX_BITS]) begin
				memory_rd_req <= 1'b0;	// end of index range.
			end
		end
	end

endmodule

// File: source/main_memory.sv
/*
 * 32K x 16 main memory, single port.
 * Registered read, plain write, cleared at start-up.
 */

`timescale 1ns/1ps

module main_memory (
	input  logic CLK,
	input  logic mem_en,
	input  logic mem_we,
	input  logic [icache_pkg::ADDR_BITS-1:0] mem_addr,
	input  logic [icache_pkg::DATA_BITS-1:0] mem_wdata,
	output logic [icache_pkg::DATA_BITS-1:0] mem_rdata
);

	logic [icache_pkg::DATA_BITS-1:0] ram [0:icache_pkg::MEM_WORDS-1];

	initial begin
		for (int i = 0; i < icache_pkg::MEM_WORDS; i++) begin
			ram[i] = '0;
		end
	end

	// a write leaves the read register alone.
	always_ff @(posedge CLK) begin
		if (mem_en) begin
			if (mem_we) begin
				ram[mem_addr] <= mem_wdata;
			end else begin
				mem_rdata <= ram[mem_addr];
			end
		end
	end

endmodule

// File: source/memory_arbiter.sv
/*
 * Main memory arbiter for the cache fill port and the data port.
 * Data port has priority; reads travel a two-stage pipeline that
 * returns owner, address and word.
 */

`timescale 1ns/1ps

module memory_arbiter (
	input  logic CLK,
	input  logic RSTb,

	// cache fill side.
	input  logic memory_rd_req,
	input  logic [icache_pkg::ADDR_BITS-1:0] memory_address,
	output logic will_queue,
	output logic memory_success,
	output logic [icache_pkg::ADDR_BITS-1:0] memory_requested_address,
	output logic [icache_pkg::DATA_BITS-1:0] memory_data,

	// data port.
	input  logic data_req,
	input  logic data_we,
	input  logic [icache_pkg::ADDR_BITS-1:0] data_address,
	input  logic [icache_pkg::DATA_BITS-1:0] data_wdata,
	output logic data_rvalid,
	output logic [icache_pkg::DATA_BITS-1:0] data_rdata,

	// main memory.
	output logic mem_en,
	output logic mem_we,
	output logic [icache_pkg::ADDR_BITS-1:0] mem_addr,
	output logic [icache_pkg::DATA_BITS-1:0] mem_wdata,
	input  logic [icache_pkg::DATA_BITS-1:0] mem_rdata
);

	logic grant_cache;
	logic rd_accept;

	logic s1_valid;	// read issued at the last edge.
	logic s1_data;	// owner, 1 = data port.
	logic [icache_pkg::ADDR_BITS-1:0] s1_address;
	logic [icache_pkg::DATA_BITS-1:0] rd_data_q;

	// ****************************************
	// grant
	// ****************************************

	assign will_queue = !data_req;
	assign grant_cache = memory_rd_req && !data_req;
	assign rd_accept = grant_cache || (data_req && !data_we);

	assign mem_en = data_req || memory_rd_req;
	assign mem_we = data_req && data_we;	// writes finish at the accepting edge.
	assign mem_addr = data_req ? data_address : memory_address;
	assign mem_wdata = data_wdata;

	// ****************************************
	// read pipeline
	// ****************************************

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			s1_valid <= 1'b0;
			memory_success <= 1'b0;
			data_rvalid <= 1'b0;
		end else begin
			s1_valid <= rd_accept;
			memory_success <= s1_valid && !s1_data;
			data_rvalid <= s1_valid && s1_data;
		end
	end

	always_ff @(posedge CLK) begin
		s1_data <= data_req;
		s1_address <= mem_addr;
		memory_requested_address <= s1_address;	// address rides with its word.
		if (s1_valid) begin
			rd_data_q <= mem_rdata;
		end
	end

	// one word register serves both owners.
	assign memory_data = rd_data_q;
	assign data_rdata = rd_data_q;

endmodule

// File: source/fetch_subsystem_top.sv
/*
 * Instruction fetch subsystem.
 * Cache, arbiter and main memory, with the fetch port
 * and the data port brought out.
 */

`timescale 1ns/1ps

module fetch_subsystem_top (
	input  logic CLK,
	input  logic RSTb,

	// fetch port.
	input  logic [icache_pkg::ADDR_BITS-1:0] fetch_address,
	output logic [icache_pkg::DATA_BITS-1:0] instruction,
	output logic fetch_miss,

	// data port.
	input  logic data_req,
	input  logic data_we,
	input  logic [icache_pkg::ADDR_BITS-1:0] data_address,
	input  logic [icache_pkg::DATA_BITS-1:0] data_wdata,
	output logic data_rvalid,
	output logic [icache_pkg::DATA_BITS-1:0] data_rdata
);

	// cache to arbiter.
	logic [icache_pkg::ADDR_BITS-1:0] memory_address;
	logic memory_rd_req;
	logic will_queue;
	logic memory_success;
	logic [icache_pkg::ADDR_BITS-1:0] memory_requested_address;
	logic [icache_pkg::DATA_BITS-1:0] memory_data;

	// arbiter to memory.
	logic mem_en;
	logic mem_we;
	logic [icache_pkg::ADDR_BITS-1:0] mem_addr;
	logic [icache_pkg::DATA_BITS-1:0] mem_wdata;
	logic [icache_pkg::DATA_BITS-1:0] mem_rdata;

	cpu_instruction_cache icache_inst (
		.CLK(CLK),
		.RSTb(RSTb),
		.cache_request_address(fetch_address),
		.instruction(instruction),
		.cache_miss(fetch_miss),
		.memory_address(memory_address),
		.memory_rd_req(memory_rd_req),
		.memory_success(memory_success),
		.memory_requested_address(memory_requested_address),
		.memory_data(memory_data),
		.will_queue(will_queue)
	);

	memory_arbiter arbiter_inst (
		.CLK(CLK),
		.RSTb(RSTb),
		.memory_rd_req(memory_rd_req),
		.memory_address(memory_address),
		.will_queue(will_queue),
		.memory_success(memory_success),
		.memory_requested_address(memory_requested_address),
		.memory_data(memory_data),
		.data_req(data_req),
		.data_we(data_we),
		.data_address(data_address),
		.data_wdata(data_wdata),
		.data_rvalid(data_rvalid),
		.data_rdata(data_rdata),
		.mem_en(mem_en),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	main_memory main_memory_inst (
		.CLK(CLK),
		.mem_en(mem_en),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

endmodule

// File: tests/tb_clock_gen.sv
/*
 * Testbench clock and reset.
 * 100 ns clock, reset held low for two cycles.
 */

`timescale 1ns/1ps

module tb_clock_gen (
	output logic CLK,
	output logic RSTb
);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	initial begin
		RSTb <= 1'b0;
		repeat (2) @(posedge CLK);
		RSTb <= 1'b1;	// released on the rising edge.
	end

endmodule

// File: tests/tb_fetch_subsystem.sv
/*
 * Testbench for the fetch subsystem.
 * Shadow memory model, LFSR stimulus, data read monitor,
 * compare task, fetch tests and watchdog.
 */

`timescale 1ns/1ps

module tb_fetch_subsystem;

	localparam logic [6:0] PAGE_A = 7'd3;
	localparam logic [6:0] PAGE_B = 7'd5;
	// preload, readback, cold, prefetch, conflict, back-pressure.
	localparam longint TEST_OPS = 512 + 32 + 8 + (1 + 300 + 255) + 8 + (40 + 6);
	localparam longint TIMEOUT_NS = TEST_OPS * 200 * 100;

	logic CLK;
	logic RSTb;
	logic [14:0] fetch_address;
	logic [15:0] instruction;
	logic fetch_miss;
	logic data_req;
	logic data_we;
	logic [14:0] data_address;
	logic [15:0] data_wdata;
	logic data_rvalid;
	logic [15:0] data_rdata;

	logic [15:0] shadow [0:32767];
	logic [31:0] lfsr_state = 32'hfcbb_86c0;
	int cycle_count = 0;
	int due_q[$];	// cycle where each data read must return.
	logic [15:0] exp_q[$];
	logic [14:0] fetch_list [0:5];

	tb_clock_gen clock_gen_inst (
		.CLK(CLK),
		.RSTb(RSTb)
	);

	fetch_subsystem_top fetch_subsystem_top_inst (
		.CLK(CLK),
		.RSTb(RSTb),
		.fetch_address(fetch_address),
		.instruction(instruction),
		.fetch_miss(fetch_miss),
		.data_req(data_req),
		.data_we(data_we),
		.data_address(data_address),
		.data_wdata(data_wdata),
		.data_rvalid(data_rvalid),
		.data_rdata(data_rdata)
	);

	// ****************************************
	// helpers
	// ****************************************

	// taps 32, 22, 2, 1.
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] result;
		logic fb;
		result = '0;
		for (int i = 0; i < count; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			result = {result[30:0], fb};
		end
		return result;
	endfunction

	function automatic logic [14:0] random_page_address();
		logic [31:0] r;
		r = random_bits(9);
		return {(r[8] ? PAGE_B : PAGE_A), r[7:0]};
	endfunction

	// what main memory holds at an address.
	function automatic logic [15:0] expected_word(input logic [14:0] addr);
		return shadow[addr];
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// hold the address until the miss clears.
	task automatic fetch_and_wait(input logic [14:0] addr, input logic expect_miss,
		input int limit);
		int n;
		n = 0;
		@(posedge CLK);
		fetch_address <= addr;
		@(posedge CLK);
		@(negedge CLK);
		if (expect_miss) begin
			check_value("fetch_miss", 32'(fetch_miss), 32'd1);
		end
		while (fetch_miss && n < limit) begin
			@(negedge CLK);
			n++;
		end
		if (fetch_miss) begin
			fail_run($sformatf("fetch of address 0x%h never stopped missing", addr));
		end else begin
			check_value("instruction", 32'(instruction), 32'(expected_word(addr)));
		end
	endtask

	// ****************************************
	// data read monitor
	// ****************************************

	always @(posedge CLK) begin
		cycle_count = cycle_count + 1;
		if (RSTb && data_req && !data_we) begin
			due_q.push_back(cycle_count + 1);
			exp_q.push_back(expected_word(data_address));
		end
	end

	always @(negedge CLK) begin
		logic [15:0] expected;
		if (data_rvalid && due_q.size() == 0) begin
			fail_run("data_rvalid pulsed with no read outstanding");
		end else if (data_rvalid && due_q[0] != cycle_count) begin
			fail_run("data_rvalid came on the wrong cycle");
		end else if (data_rvalid) begin
			void'(due_q.pop_front());
			expected = exp_q.pop_front();
			check_value("data_rdata", 32'(data_rdata), 32'(expected));
		end else if (due_q.size() != 0 && due_q[0] == cycle_count) begin
			fail_run("data_rvalid missing for an accepted read");
		end
	end

	initial begin
		#(TIMEOUT_NS);
		fail_run("timeout, the tests did not finish in time");
	end

	// ****************************************
	// tests
	// ****************************************

	initial begin
		logic [14:0] addr;
		logic [15:0] word;
		fetch_address <= '0;
		data_req <= 1'b0;
		data_we <= 1'b0;
		data_address <= '0;
		data_wdata <= '0;
		for (int i = 0; i < 32768; i++) begin
			shadow[i] = '0;
		end
		@(posedge CLK);
		while (!RSTb) @(posedge CLK);

		// preload two pages, fetch held at 0.
		for (int p = 0; p < 2; p++) begin
			for (int i = 0; i < 256; i++) begin
				word = 16'(random_bits(16));
				addr = {(p == 0 ? PAGE_A : PAGE_B), 8'(i)};
				shadow[addr] = word;
				@(posedge CLK);
				data_req <= 1'b1;
				data_we <= 1'b1;
				data_address <= addr;
				data_wdata <= word;
			end
		end
		for (int i = 0; i < 32; i++) begin
			@(posedge CLK);
			data_we <= 1'b0;
			data_address <= random_page_address();
		end
		@(posedge CLK);
		data_req <= 1'b0;
		repeat (4) @(posedge CLK);

		// cold misses, descending so no prefetch gets there first.
		for (int k = 0; k < 8; k++) begin
			fetch_and_wait({PAGE_A, 8'(248 - k * 32)}, 1'b1, 20);
		end

		// prefetch of the rest of a page.
		fetch_and_wait({PAGE_B, 8'h00}, 1'b1, 20);
		repeat (300) @(posedge CLK);
		for (int i = 1; i < 256; i++) begin
			addr = {PAGE_B, 8'(i)};
			@(posedge CLK);
			fetch_address <= addr;
			@(posedge CLK);
			@(negedge CLK);
			check_value("fetch_miss", 32'(fetch_miss), 32'd0);
			check_value("instruction", 32'(instruction), 32'(expected_word(addr)));
		end

		// same index, two pages.
		for (int k = 0; k < 8; k++) begin
			fetch_and_wait({((k % 2 == 0) ? PAGE_A : PAGE_B), 8'h10}, 1'b1, 20);
		end

		// fetches under continuous data reads.
		for (int k = 0; k < 6; k++) begin
			fetch_list[k] = random_page_address();
		end
		fork
			begin
				for (int i = 0; i < 40; i++) begin
					@(posedge CLK);
					data_req <= 1'b1;
					data_we <= 1'b0;
					data_address <= random_page_address();
				end
				@(posedge CLK);
				data_req <= 1'b0;
			end
			begin
				for (int k = 0; k < 6; k++) begin
					fetch_and_wait(fetch_list[k], 1'b0, 150);
				end
			end
		join
		repeat (4) @(posedge CLK);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: compile.f
source/icache_pkg.sv
source/bram.sv
source/cpu_instruction_cache.sv
source/main_memory.sv
source/memory_arbiter.sv
source/fetch_subsystem_top.sv
tests/tb_clock_gen.sv
tests/tb_fetch_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch subsystem testbench with Verilator.

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps -f compile.f \
	--top-module tb_fetch_subsystem > sim.log 2>&1 &&
	./obj_dir/Vtb_fetch_subsystem >> sim.log 2>&1 ||
	echo "build or simulation stopped with an error status" >> sim.log

if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"
